//--- src.f
hdl/coreTypes.sv
hdl/instFetch.sv
hdl/instDecoder.sv
hdl/decodeStage.sv
hdl/registerFile.sv
hdl/hazardControl.sv
hdl/executeStage.sv
hdl/coreTop.sv
tests/clockGen.sv
tests/coreTb.sv

//--- Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -j 0
TOP       ?= coreTb
FILELIST  ?= src.f
OBJDIR    ?= obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx '>>> PASS'

clean:
	rm -rf $(OBJDIR)

//--- tests/coreTb.sv
`timescale 1ns/1ps
`default_nettype none

module coreTb;

  localparam int IMEM_DEPTH   = 64;
  localparam int DMEM_DEPTH   = 16;
  localparam int DAW          = $clog2(DMEM_DEPTH);
  localparam int NUM_PROGS    = 5;
  localparam int NUM_INSTS    = 24;
  localparam int CLK_PERIOD   = 100;
  localparam int LIMIT_CYCLES = NUM_PROGS * (NUM_INSTS * 3 + 20) + 10; // +10 for reset
  localparam logic [31:0] EBREAK = 32'h00100073;

  typedef struct packed {
    logic [31:0] pc;
    logic [4:0]  rd;
    logic [31:0] data;
  } retireT;

  logic                clk;
  logic                arstN;
  logic                progValid;
  coreTypes::progWrite prog;
  logic                start;
  logic                retireValid;
  coreTypes::regAddr   retireRd;
  coreTypes::dataWord  retireData;
  logic [31:0]         retirePc;
  logic                halted;

  logic [31:0] lfsr;
  logic [31:0] progMem [NUM_INSTS + 1];
  logic [31:0] modelRegs [32];
  logic [31:0] modelMem [DMEM_DEPTH];
  logic        memWritten [DMEM_DEPTH]; // loads only hit stored words
  retireT      expQ [$];
  int          errors;
  int          retired;
  int          haltCount;
  int          progsStarted;

  clockGen #(.PERIOD(CLK_PERIOD), .RESET_CYCLES(2)) uClock (.clk, .arstN);

  coreTop #(.IMEM_DEPTH(IMEM_DEPTH), .DMEM_DEPTH(DMEM_DEPTH)) u_dut (
    .clk, .arstN, .progValid, .prog, .start,
    .retireValid, .retireRd, .retireData, .retirePc, .halted
  );

  function automatic logic lfsrBit();
    logic out;
    out  = lfsr[0];
    lfsr = lfsr >> 1;
    if (out) lfsr = lfsr ^ 32'h80200003; // galois taps 32,22,2,1
    return out;
  endfunction

  function automatic logic [31:0] randBits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) v = {v[30:0], lfsrBit()};
    return v;
  endfunction

  // ISA model, one instruction per call, queues the retirement it implies
  function automatic void refExec(input logic [31:0] inst, input logic [31:0] pc);
    logic [4:0]  rd;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] iImm;
    logic [31:0] sImm;
    logic [31:0] addr;
    logic [31:0] val;
    logic        wr;
    retireT      r;
    rd   = inst[11:7];
    a    = modelRegs[inst[19:15]];
    b    = modelRegs[inst[24:20]];
    iImm = {{20{inst[31]}}, inst[31:20]};
    sImm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    val  = '0;
    wr   = 1'b1;
    case (inst[6:0])
      7'b0110011: begin
        case ({inst[31:25], inst[14:12]})
          10'b0000000_000: val = a + b;
          10'b0100000_000: val = a - b;
          10'b0000000_111: val = a & b;
          10'b0000000_110: val = a | b;
          10'b0000000_100: val = a ^ b;
          default:         wr  = 1'b0;
        endcase
      end
      7'b0010011: val = a + iImm;
      7'b0110111: val = {inst[31:12], 12'h000};
      7'b0000011: begin
        addr = a + iImm;
        val  = modelMem[addr[DAW-1:0]];
      end
      7'b0100011: begin
        addr = a + sImm;
        modelMem[addr[DAW-1:0]] = b;
        wr = 1'b0;
      end
      default: wr = 1'b0; // ebreak retires without a write
    endcase
    if (wr && rd != 5'd0) begin
      modelRegs[rd] = val;
    end else begin
      rd  = 5'd0;
      val = '0;
    end
    r.pc   = pc;
    r.rd   = rd;
    r.data = val;
    expQ.push_back(r);
  endfunction

  // kind 0 keeps neighbours independent, 1 chains them, 2 is memory heavy
  task automatic buildProgram(input int kind);
    int          op;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [4:0]  prevRd;
    logic [11:0] imm;
    logic [31:0] word;
    prevRd = 5'd0;
    for (int i = 0; i < NUM_INSTS; i++) begin
      op = int'(randBits(4)) % 9;
      if (kind == 2 && op < 5) op = 7 + op % 2;
      rd  = 5'(randBits(3));
      rs1 = 5'(randBits(3));
      rs2 = 5'(randBits(3));
      while (kind == 0 && prevRd != 5'd0 && (rs1 == prevRd || rs2 == prevRd)) begin
        rs1 = 5'(randBits(3));
        rs2 = 5'(randBits(3));
      end
      if (kind == 1) rs1 = prevRd;
      imm = (op >= 7) ? 12'(randBits(DAW)) : 12'(randBits(12)); // x0 base, word index
      if (op == 7 && !memWritten[imm[DAW-1:0]]) op = 8;
      if (kind == 1 && op == 8) rs2 = prevRd;
      case (op)
        0: word = {7'b0000000, rs2, rs1, 3'b000, rd, 7'b0110011};
        1: word = {7'b0100000, rs2, rs1, 3'b000, rd, 7'b0110011};
        2: word = {7'b0000000, rs2, rs1, 3'b111, rd, 7'b0110011};
        3: word = {7'b0000000, rs2, rs1, 3'b110, rd, 7'b0110011};
        4: word = {7'b0000000, rs2, rs1, 3'b100, rd, 7'b0110011};
        5: word = {imm, rs1, 3'b000, rd, 7'b0010011};
        6: word = {20'(randBits(20)), rd, 7'b0110111};
        7: word = {imm, 5'd0, 3'b010, rd, 7'b0000011};
        default: begin
          word = {imm[11:5], rs2, 5'd0, 3'b010, imm[4:0], 7'b0100011};
          memWritten[imm[DAW-1:0]] = 1'b1;
        end
      endcase
      prevRd     = (op == 8) ? 5'd0 : rd;
      progMem[i] = word;
      refExec(word, 32'(i * 4));
    end
    progMem[NUM_INSTS] = EBREAK;
    refExec(EBREAK, 32'(NUM_INSTS * 4));
  endtask

  task automatic runProgram(input int num);
    for (int i = 0; i <= NUM_INSTS; i++) begin
      @(posedge clk);
      progValid <= 1'b1;
      prog.addr <= 32'(i);
      prog.data <= progMem[i];
    end
    @(posedge clk);
    progValid    <= 1'b0;
    start        <= 1'b1;
    progsStarted <= num + 1;
    @(posedge clk);
    start <= 1'b0;
    while (haltCount < num + 1) @(posedge clk);
    repeat (4) @(posedge clk); // late retires would show here
  endtask

  task automatic checkValue(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
    if (got !== exp) begin
      $display("[ERROR] %s got %h expected %h at %0t", name, got, exp, $time);
      errors++;
    end
  endtask

  always @(negedge clk) begin : compare
    retireT exp;
    if (!arstN) begin
      checkValue("retireValid", 32'(retireValid), 32'd0);
      checkValue("halted", 32'(halted), 32'd0);
    end else begin
      if (retireValid) begin
        if (expQ.size() == 0) begin
          $display("retire at pc %h when no instruction was outstanding", retirePc);
          errors++;
        end else begin
          exp = expQ.pop_front();
          checkValue("retirePc", retirePc, exp.pc);
          checkValue("retireRd", 32'(retireRd), 32'(exp.rd));
          checkValue("retireData", retireData, exp.data);
          retired++;
        end
      end
      if (halted) begin
        haltCount++;
        checkValue("haltCount", 32'(haltCount), 32'(progsStarted));
        if (expQ.size() != 0) begin
          $display("halted raised with %0d instructions still to retire", expQ.size());
          errors++;
        end
      end
    end
  end

  initial begin : watchdog
    #(LIMIT_CYCLES * CLK_PERIOD);
    $display("timeout after %0d cycles, the core never finished its programs",
             LIMIT_CYCLES);
    $display(">>> FAIL");
    $finish;
  end

  initial begin
    progValid    = 1'b0;
    prog         = '0;
    start        = 1'b0;
    lfsr         = 32'h2dbb;
    errors       = 0;
    retired      = 0;
    haltCount    = 0;
    progsStarted = 0;
    for (int i = 0; i < 32; i++) modelRegs[i] = '0;
    for (int i = 0; i < DMEM_DEPTH; i++) begin
      modelMem[i]   = '0;
      memWritten[i] = 1'b0;
    end
    @(posedge arstN);
    @(posedge clk);
    for (int p = 0; p < NUM_PROGS; p++) begin
      buildProgram(p % 4); // kind 3 is unconstrained
      runProgram(p);
    end
    $display("retired %0d, halts %0d, errors %0d", retired, haltCount, errors);
    if (errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- tests/clockGen.sv
`timescale 1ns/1ps
`default_nettype none

module clockGen #(
  parameter int PERIOD       = 100,
  parameter int RESET_CYCLES = 2
) (
  output logic clk,
  output logic arstN
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  initial begin
    arstN = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    arstN <= 1'b1; // release on a clock edge
  end

endmodule

`default_nettype wire

//--- hdl/coreTop.sv
`timescale 1ns/1ps
`default_nettype none

module coreTop #(
  parameter int IMEM_DEPTH = 64,
  parameter int DMEM_DEPTH = 16
) (
  input  logic                clk,
  input  logic                arstN,
  input  logic                progValid,
  input  coreTypes::progWrite prog,
  input  logic                start,
  output logic                retireValid,
  output coreTypes::regAddr   retireRd,
  output coreTypes::dataWord  retireData,
  output logic [31:0]         retirePc,
  output logic                halted
);

  coreTypes::fetchReg  fetchQ;
  coreTypes::decodeReg decodeQ;
  coreTypes::writeReg  writeQ;
  coreTypes::regAddr   rs1Addr;
  coreTypes::regAddr   rs2Addr;
  coreTypes::dataWord  rs1Data;
  coreTypes::dataWord  rs2Data;
  logic                usesRs1;
  logic                usesRs2;
  logic                fetchEnable;
  logic                stall;

  instFetch #(.IMEM_DEPTH(IMEM_DEPTH)) uFetch (
    .clk, .arstN, .progValid, .prog, .fetchEnable, .stall,
    .fetchOut (fetchQ)
  );

  decodeStage uDecode (
    .clk, .arstN, .stall, .rs1Data, .rs2Data, .rs1Addr, .rs2Addr, .usesRs1, .usesRs2,
    .fetchIn   (fetchQ),
    .decodeOut (decodeQ)
  );

  registerFile uRegs (
    .clk, .arstN, .rs1Addr, .rs2Addr, .rs1Data, .rs2Data,
    .wb (writeQ)
  );

  hazardControl uHazard (
    .clk, .arstN, .start, .rs1Addr, .rs2Addr, .usesRs1, .usesRs2,
    .fetchEnable, .stall, .halted,
    .decodeIn (decodeQ),
    .wbIn     (writeQ)
  );

  executeStage #(.DMEM_DEPTH(DMEM_DEPTH)) uExecute (
    .clk, .arstN,
    .decodeIn (decodeQ),
    .wbOut    (writeQ)
  );

  assign retireValid = writeQ.valid; // bubbles never retire
  assign retireRd    = writeQ.rd.rdAddr;
  assign retireData  = writeQ.result;
  assign retirePc    = writeQ.pc;

endmodule

`default_nettype wire

//--- hdl/executeStage.sv
`timescale 1ns/1ps
`default_nettype none

module executeStage #(
  parameter int DMEM_DEPTH = 16
) (
  input  logic                clk,
  input  logic                arstN,
  input  coreTypes::decodeReg decodeIn,
  output coreTypes::writeReg  wbOut
);

  localparam int DAW = $clog2(DMEM_DEPTH); // depth is a power of two

  coreTypes::dataWord dmem [DMEM_DEPTH];
  coreTypes::dataWord opB;
  coreTypes::dataWord aluOut;
  coreTypes::dataWord effAddr;
  coreTypes::dataWord result;

  assign opB     = decodeIn.bSel == coreTypes::selImm ? decodeIn.imm : decodeIn.rs2Data;
  assign effAddr = decodeIn.rs1Data + decodeIn.imm; // word index

  always_comb begin
    case (decodeIn.alu)
      coreTypes::aluAdd:   aluOut = decodeIn.rs1Data + opB;
      coreTypes::aluSub:   aluOut = decodeIn.rs1Data - opB;
      coreTypes::aluAnd:   aluOut = decodeIn.rs1Data & opB;
      coreTypes::aluOr:    aluOut = decodeIn.rs1Data | opB;
      coreTypes::aluXor:   aluOut = decodeIn.rs1Data ^ opB;
      coreTypes::aluPassB: aluOut = opB;
      default:             aluOut = '0;
    endcase
  end

  // non-writing instructions retire with zero data
  assign result = !decodeIn.rd.wEnable ? '0
                : decodeIn.isLoad      ? dmem[effAddr[DAW-1:0]] : aluOut;

  always_ff @(posedge clk) begin
    if (decodeIn.valid && decodeIn.isStore) begin
      dmem[effAddr[DAW-1:0]] <= decodeIn.rs2Data;
    end
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      wbOut <= '0;
    end else begin
      wbOut.valid  <= decodeIn.valid;
      wbOut.pc     <= decodeIn.pc;
      wbOut.rd     <= decodeIn.rd;
      wbOut.result <= result;
      wbOut.isHalt <= decodeIn.isHalt;
    end
  end

endmodule

`default_nettype wire

//--- hdl/hazardControl.sv
`timescale 1ns/1ps
`default_nettype none

module hazardControl (
  input  logic                clk,
  input  logic                arstN,
  input  logic                start,
  input  coreTypes::regAddr   rs1Addr,
  input  coreTypes::regAddr   rs2Addr,
  input  logic                usesRs1,
  input  logic                usesRs2,
  input  coreTypes::decodeReg decodeIn,
  input  coreTypes::writeReg  wbIn,
  output logic                fetchEnable,
  output logic                stall,
  output logic                halted
);

  typedef enum logic [1:0] {stIdle, stRun, stDrain, stDone} stateT;

  stateT state;
  logic  haltInDecode;
  logic  rs1Hit;
  logic  rs2Hit;

  assign haltInDecode = decodeIn.valid && decodeIn.isHalt;
  // only the decode register can be ahead of the register file
  assign rs1Hit = usesRs1 && decodeIn.rd.wEnable && rs1Addr == decodeIn.rd.rdAddr;
  assign rs2Hit = usesRs2 && decodeIn.rd.wEnable && rs2Addr == decodeIn.rd.rdAddr;

  assign fetchEnable = state == stRun && !haltInDecode;
  assign stall       = state == stRun && (rs1Hit || rs2Hit);
  assign halted      = state == stDone;

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      state <= stIdle;
    end else begin
      case (state)
        stIdle:  if (start) state <= stRun;
        stRun:   if (haltInDecode) state <= stDrain;
        stDrain: if (wbIn.valid && wbIn.isHalt) state <= stDone;
        stDone:  state <= stIdle; // halted pulse
        default: state <= stIdle;
      endcase
    end
  end

  // a halt never stalls and one bubble clears a dependent pair
  assertStallRun: assert property (@(posedge clk) disable iff (!arstN)
    stall |-> fetchEnable ##1 !stall);

endmodule

`default_nettype wire

//--- hdl/registerFile.sv
`timescale 1ns/1ps
`default_nettype none

module registerFile (
  input  logic               clk,
  input  logic               arstN,
  input  coreTypes::regAddr  rs1Addr,
  input  coreTypes::regAddr  rs2Addr,
  input  coreTypes::writeReg wb,
  output coreTypes::dataWord rs1Data,
  output coreTypes::dataWord rs2Data
);

  coreTypes::dataWord regs [1:31];
  logic               wrEn;

  assign wrEn = wb.valid && wb.rd.wEnable && wb.rd.rdAddr != 5'd0;

  function automatic coreTypes::dataWord readPort(input coreTypes::regAddr addr);
    if (addr == 5'd0) begin
      return '0;
    end else if (wrEn && addr == wb.rd.rdAddr) begin
      return wb.result; // same-cycle write shows through
    end
    return regs[addr];
  endfunction

  always_comb begin
    rs1Data = readPort(rs1Addr);
    rs2Data = readPort(rs2Addr);
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wrEn) begin
      regs[wb.rd.rdAddr] <= wb.result;
    end
  end

endmodule

`default_nettype wire

//--- hdl/decodeStage.sv
`timescale 1ns/1ps
`default_nettype none

module decodeStage (
  input  logic                clk,
  input  logic                arstN,
  input  coreTypes::fetchReg  fetchIn,
  input  logic                stall,
  input  coreTypes::dataWord  rs1Data,
  input  coreTypes::dataWord  rs2Data,
  output coreTypes::regAddr   rs1Addr,
  output coreTypes::regAddr   rs2Addr,
  output logic                usesRs1,
  output logic                usesRs2,
  output coreTypes::decodeReg decodeOut
);

  coreTypes::rdCtrl   rd;
  coreTypes::dataWord imm;
  coreTypes::aluOp    alu;
  coreTypes::opSel    bSel;
  logic               decUsesRs1;
  logic               decUsesRs2;
  logic               isLoad;
  logic               isStore;
  logic               isHalt;
  logic               bubble;

  instDecoder uDecoder (
    .inst    (fetchIn.inst),
    .rs1Addr (rs1Addr),
    .rs2Addr (rs2Addr),
    .rd      (rd),
    .imm     (imm),
    .alu     (alu),
    .bSel    (bSel),
    .usesRs1 (decUsesRs1),
    .usesRs2 (decUsesRs2),
    .isLoad  (isLoad),
    .isStore (isStore),
    .isHalt  (isHalt)
  );

  assign usesRs1 = decUsesRs1 && fetchIn.valid; // no hazard from an empty slot
  assign usesRs2 = decUsesRs2 && fetchIn.valid;

  // nothing follows a halt already sitting in the decode register
  assign bubble = stall || !fetchIn.valid || (decodeOut.valid && decodeOut.isHalt);

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      decodeOut <= '0;
    end else if (bubble) begin
      decodeOut <= '0; // all flags off
    end else begin
      decodeOut.valid   <= 1'b1;
      decodeOut.pc      <= fetchIn.pc;
      decodeOut.rs1Data <= rs1Data;
      decodeOut.rs2Data <= rs2Data;
      decodeOut.imm     <= imm;
      decodeOut.rd      <= rd;
      decodeOut.alu     <= alu;
      decodeOut.bSel    <= bSel;
      decodeOut.isLoad  <= isLoad;
      decodeOut.isStore <= isStore;
      decodeOut.isHalt  <= isHalt;
    end
  end

  // stall only behind a writer and its bubble writes nothing
  assertBubbleQuiet: assert property (@(posedge clk) disable iff (!arstN)
    stall |-> decodeOut.rd.wEnable ##1 (!decodeOut.rd.wEnable && !decodeOut.isStore));

endmodule

`default_nettype wire

//--- hdl/instDecoder.sv
`timescale 1ns/1ps
`default_nettype none

module instDecoder (
  input  coreTypes::instWord inst,
  output coreTypes::regAddr  rs1Addr,
  output coreTypes::regAddr  rs2Addr,
  output coreTypes::rdCtrl   rd,
  output coreTypes::dataWord imm,
  output coreTypes::aluOp    alu,
  output coreTypes::opSel    bSel,
  output logic               usesRs1,
  output logic               usesRs2,
  output logic               isLoad,
  output logic               isStore,
  output logic               isHalt
);

  logic writesRd; // encoding targets rd

  always_comb begin
    rs1Addr  = inst.rType.rs1;
    rs2Addr  = inst.rType.rs2;
    imm      = '0;
    alu      = coreTypes::aluNop;
    bSel     = coreTypes::selReg;
    usesRs1  = 1'b0;
    usesRs2  = 1'b0;
    writesRd = 1'b0;
    isLoad   = 1'b0;
    isStore  = 1'b0;
    isHalt   = 1'b0;
    case (inst.rType.opcode)
      coreTypes::OPC_OP: begin
        usesRs1  = 1'b1;
        usesRs2  = 1'b1;
        writesRd = 1'b1;
        case ({inst.rType.funct7, inst.rType.funct3})
          10'b0000000_000: alu = coreTypes::aluAdd;
          10'b0100000_000: alu = coreTypes::aluSub;
          10'b0000000_100: alu = coreTypes::aluXor;
          10'b0000000_110: alu = coreTypes::aluOr;
          10'b0000000_111: alu = coreTypes::aluAnd;
          default: begin // unsupported R op
            usesRs1  = 1'b0;
            usesRs2  = 1'b0;
            writesRd = 1'b0;
          end
        endcase
      end
      coreTypes::OPC_OPIMM: begin
        if (inst.iType.funct3 == 3'b000) begin // addi only
          alu      = coreTypes::aluAdd;
          bSel     = coreTypes::selImm;
          imm      = {{20{inst.iType.imm12[11]}}, inst.iType.imm12};
          usesRs1  = 1'b1;
          writesRd = 1'b1;
        end
      end
      coreTypes::OPC_LUI: begin
        alu      = coreTypes::aluPassB;
        bSel     = coreTypes::selImm;
        imm      = {inst.uType.imm20, 12'h000};
        writesRd = 1'b1;
      end
      coreTypes::OPC_LOAD: begin
        if (inst.iType.funct3 == 3'b010) begin // lw
          bSel     = coreTypes::selImm;
          imm      = {{20{inst.iType.imm12[11]}}, inst.iType.imm12};
          usesRs1  = 1'b1;
          writesRd = 1'b1;
          isLoad   = 1'b1;
        end
      end
      coreTypes::OPC_STORE: begin
        if (inst.sType.funct3 == 3'b010) begin // sw
          bSel    = coreTypes::selImm;
          imm     = {{20{inst.sType.immHi[6]}}, inst.sType.immHi, inst.sType.immLo};
          usesRs1 = 1'b1;
          usesRs2 = 1'b1;
          isStore = 1'b1;
        end
      end
      coreTypes::OPC_SYSTEM: begin
        // ebreak is the only system op kept
        isHalt = inst.iType.imm12 == 12'h001 && inst.iType.funct3 == 3'b000
              && inst.iType.rs1 == 5'd0 && inst.iType.rd == 5'd0;
      end
      default: ;
    endcase
    rd.wEnable = writesRd && inst.rType.rd != 5'd0; // x0 never written
    rd.rdAddr  = rd.wEnable ? inst.rType.rd : 5'd0;
  end

endmodule

`default_nettype wire

//--- hdl/instFetch.sv
`timescale 1ns/1ps
`default_nettype none

module instFetch #(
  parameter int IMEM_DEPTH = 64
) (
  input  logic                clk,
  input  logic                arstN,
  input  logic                progValid,
  input  coreTypes::progWrite prog,
  input  logic                fetchEnable,
  input  logic                stall,
  output coreTypes::fetchReg  fetchOut
);

  localparam int IAW = $clog2(IMEM_DEPTH);

  coreTypes::instWord imem [IMEM_DEPTH];
  logic [31:0]        pc;

  always_ff @(posedge clk) begin
    if (progValid) begin
      imem[prog.addr[IAW-1:0]] <= prog.data; // program load port
    end
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      pc       <= '0;
      fetchOut <= '0;
    end else if (!fetchEnable) begin
      pc             <= '0; // next run starts at 0
      fetchOut.valid <= 1'b0;
    end else if (!stall) begin
      fetchOut.valid <= 1'b1;
      fetchOut.pc    <= pc;
      fetchOut.inst  <= imem[pc[IAW+1:2]];
      pc             <= pc + 32'd4;
    end
  end

  // loading is only legal while the pipe is empty
  assertProgIdle: assert property (@(posedge clk) disable iff (!arstN)
    progValid |-> !fetchEnable && !fetchOut.valid);

endmodule

`default_nettype wire

//--- hdl/coreTypes.sv
`default_nettype none

package coreTypes;

  typedef logic [4:0]  regAddr;
  typedef logic [31:0] dataWord;

  // one instruction word, viewed per format
  typedef union packed {
    struct packed {
      logic [6:0] funct7;
      regAddr     rs2;
      regAddr     rs1;
      logic [2:0] funct3;
      regAddr     rd;
      logic [6:0] opcode;
    } rType;
    struct packed {
      logic [11:0] imm12;
      regAddr      rs1;
      logic [2:0]  funct3;
      regAddr      rd;
      logic [6:0]  opcode;
    } iType;
    struct packed {
      logic [6:0] immHi;
      regAddr     rs2;
      regAddr     rs1;
      logic [2:0] funct3;
      logic [4:0] immLo;
      logic [6:0] opcode;
    } sType;
    struct packed {
      logic [19:0] imm20;
      regAddr      rd;
      logic [6:0]  opcode;
    } uType;
  } instWord;

  typedef enum logic [2:0] {
    aluNop,
    aluAdd,
    aluSub,
    aluAnd,
    aluOr,
    aluXor,
    aluPassB
  } aluOp;

  typedef enum logic {
    selReg,
    selImm
  } opSel;

  typedef struct packed {
    logic   wEnable;
    regAddr rdAddr;
  } rdCtrl;

  typedef struct packed {
    logic        valid;
    logic [31:0] pc;
    instWord     inst;
  } fetchReg;

  typedef struct packed {
    logic        valid;
    logic [31:0] pc;
    dataWord     rs1Data;
    dataWord     rs2Data;
    dataWord     imm;
    rdCtrl       rd;
    aluOp        alu;
    opSel        bSel;
    logic        isLoad;
    logic        isStore;
    logic        isHalt;
  } decodeReg;

  typedef struct packed {
    logic        valid;
    logic [31:0] pc;
    rdCtrl       rd;
    dataWord     result;
    logic        isHalt;
  } writeReg;

  typedef struct packed {
    logic [31:0] addr; // word address
    instWord     data;
  } progWrite;

  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OPIMM  = 7'b0010011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

endpackage

`default_nettype wire
